//--- hdl/cpu_types_pkg.sv
package cpu_types_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////////////////////////////////////////

    // machine word width
    localparam int xlen = 32;

    // architectural register count
    localparam int num_regs = 8;

    // byte address into the tagged memory
    typedef logic [15:0] addr_t;

    // register and alu data
    typedef logic [xlen-1:0] data_t;

    // raw instruction word as wide as data
    typedef logic [xlen-1:0] inst_t;

    // register index wide enough for num_regs entries
    typedef logic [$clog2(num_regs)-1:0] reg_idx_t;

    ////////////////////////////////////////////////////////////////////////////
    // memory port
    ////////////////////////////////////////////////////////////////////////////

    // transaction tag
    // zero on the request cycle means memory busy
    typedef logic [3:0] mem_tag_t;

    // command to memory with only instruction loads here
    typedef enum logic [1:0] {
        mem_none = 2'h0,
        mem_load = 2'h1
    } mem_cmd_t;

endpackage

//--- hdl/cpu_isa_pkg.sv
package cpu_isa_pkg;

    // fetch starts here after reset
    localparam cpu_types_pkg::addr_t reset_pc = 16'h0000;

    ////////////////////////////////////////////////////////////////////////////
    // instruction word layout
    ////////////////////////////////////////////////////////////////////////////

    localparam int op_msb  = 31;
    localparam int op_lsb  = 28;
    localparam int rd_msb  = 27;
    localparam int rd_lsb  = 25;
    localparam int rs1_msb = 24;
    localparam int rs1_lsb = 22;
    localparam int rs2_msb = 21;
    localparam int rs2_lsb = 19;
    localparam int imm_msb = 15;
    localparam int imm_lsb = 0;

    // signed immediate with branch offsets counted in words
    typedef logic signed [imm_msb-imm_lsb:0] imm_t;

    // any code not listed is illegal
    typedef enum logic [op_msb-op_lsb:0] {
        op_addi = 4'h0,
        op_add  = 4'h1,
        op_sub  = 4'h2,
        op_mul  = 4'h3,
        op_beq  = 4'h4,
        op_halt = 4'h5
    } opcode_t;

    typedef enum logic [1:0] {
        no_error      = 2'h0,
        halted_on_wfi = 2'h1,
        illegal_inst  = 2'h2
    } exc_code_t;

    // decode stage output held in the decode register
    typedef struct packed {
        logic                  valid;
        cpu_types_pkg::addr_t    pc;
        cpu_types_pkg::addr_t    npc;
        opcode_t               op;
        cpu_types_pkg::reg_idx_t rd;
        cpu_types_pkg::reg_idx_t rs1;
        cpu_types_pkg::reg_idx_t rs2;
        imm_t                  imm;
        logic                  writes_rd;
        logic                  illegal;
    } decode_pkt_t;

endpackage

//--- hdl/if_id_if.sv
`timescale 1ns/1ns

// fetch to decode bundle
// one copy on each side of the if/id register
interface if_id_if;

    logic                 valid;
    cpu_types_pkg::addr_t pc;
    cpu_types_pkg::addr_t npc;
    cpu_types_pkg::inst_t inst;

    // producer side
    modport fetch_mp (
        output valid, pc, npc, inst
    );

    // consumer side
    modport decode_mp (
        input valid, pc, npc, inst
    );

endinterface

//--- hdl/stage_fetch.sv
`timescale 1ns/1ns

module stage_fetch (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     stall,
    input  logic                     squash,
    input  cpu_types_pkg::addr_t     redirect_pc,
    input  logic                     halt,
    input  cpu_types_pkg::mem_tag_t  mem_txn_tag,
    input  cpu_types_pkg::data_t     mem_data,
    input  cpu_types_pkg::mem_tag_t  mem_data_tag,
    output cpu_types_pkg::mem_cmd_t  mem_cmd,
    output cpu_types_pkg::addr_t     mem_addr,
    if_id_if.fetch_mp                fetch
);

    // pc of the word being fetched or held
    cpu_types_pkg::addr_t    pc;
    cpu_types_pkg::addr_t    next_pc;
    // tag of the one request in flight
    logic                    pending;
    cpu_types_pkg::mem_tag_t pend_tag;
    // captured word waiting for decode
    logic                    out_valid;
    cpu_types_pkg::inst_t    word;
    // low through reset to keep the bus quiet
    logic                    active;

    logic take;
    logic req;
    logic hit;

    assign next_pc = pc + 16'd4;

    // held word goes into if/id this cycle
    assign take = out_valid && !stall;

    // new request when nothing is in flight and fetch is neither halted nor redirecting
    // a stall also blocks it
    assign req = active && !pending && !halt && !squash && !stall;

    // response for the outstanding tag
    assign hit = pending && (mem_data_tag == pend_tag) && !squash;

    ////////////////////////////////////////////////////////////////////////////
    // memory request
    ////////////////////////////////////////////////////////////////////////////

    assign mem_cmd  = req ? cpu_types_pkg::mem_load : cpu_types_pkg::mem_none;
    // when the held word leaves this cycle, ask for the one after it
    assign mem_addr = take ? next_pc : pc;

    ////////////////////////////////////////////////////////////////////////////
    // pc and tag tracking
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc        <= cpu_isa_pkg::reset_pc;
            pending   <= 1'b0;
            pend_tag  <= '0;
            out_valid <= 1'b0;
            active    <= 1'b0;
        end else begin
            active <= 1'b1;
            if (squash) begin
                // abandon whatever is in flight or held
                pc        <= redirect_pc;
                pending   <= 1'b0;
                pend_tag  <= '0;
                out_valid <= 1'b0;
            end else begin
                if (take) begin
                    pc        <= next_pc;
                    out_valid <= 1'b0;
                end
                // nonzero tag means accepted
                if (req && (mem_txn_tag != '0)) begin
                    pending  <= 1'b1;
                    pend_tag <= mem_txn_tag;
                end
                if (hit) begin
                    pending   <= 1'b0;
                    pend_tag  <= '0;
                    out_valid <= 1'b1;
                end
            end
        end
    end

    // instruction payload
    always_ff @(posedge clock) begin
        if (hit) begin
            word <= mem_data;
        end
    end

    assign fetch.valid = out_valid;
    assign fetch.pc    = pc;
    assign fetch.npc   = next_pc;
    assign fetch.inst  = word;

endmodule

//--- hdl/stage_decode.sv
`timescale 1ns/1ns

module stage_decode (
    if_id_if.decode_mp               inst_in,
    output cpu_isa_pkg::decode_pkt_t pkt
);

    cpu_types_pkg::inst_t inst;
    cpu_isa_pkg::opcode_t op;
    cpu_types_pkg::reg_idx_t rd;
    logic known;
    logic alu_op;

    assign inst = inst_in.inst;

    ////////////////////////////////////////////////////////////////////////////
    // field slicing
    ////////////////////////////////////////////////////////////////////////////

    assign op = cpu_isa_pkg::opcode_t'(inst[cpu_isa_pkg::op_msb:cpu_isa_pkg::op_lsb]);
    assign rd = inst[cpu_isa_pkg::rd_msb:cpu_isa_pkg::rd_lsb];

    // classify the opcode
    always_comb begin
        known  = 1'b1;
        alu_op = 1'b0;
        case (op)
            cpu_isa_pkg::op_addi,
            cpu_isa_pkg::op_add,
            cpu_isa_pkg::op_sub,
            cpu_isa_pkg::op_mul: begin
                alu_op = 1'b1;
            end
            cpu_isa_pkg::op_beq,
            cpu_isa_pkg::op_halt: begin
                alu_op = 1'b0;
            end
            default: begin
                // unlisted code
                known = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // packet
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        pkt.valid = inst_in.valid;
        pkt.pc    = inst_in.pc;
        pkt.npc   = inst_in.npc;
        pkt.op    = op;
        pkt.rd    = rd;
        pkt.rs1   = inst[cpu_isa_pkg::rs1_msb:cpu_isa_pkg::rs1_lsb];
        pkt.rs2   = inst[cpu_isa_pkg::rs2_msb:cpu_isa_pkg::rs2_lsb];
        pkt.imm   = inst[cpu_isa_pkg::imm_msb:cpu_isa_pkg::imm_lsb];
        // r0 writes are dropped here
        pkt.writes_rd = inst_in.valid && alu_op && (rd != '0);
        pkt.illegal   = inst_in.valid && !known;
    end

endmodule

//--- hdl/exec_commit.sv
`timescale 1ns/1ns

module exec_commit (
    input  logic                     clock,
    input  logic                     rst_n,
    input  cpu_isa_pkg::decode_pkt_t pkt,
    input  cpu_types_pkg::data_t     rs1_data,
    input  cpu_types_pkg::data_t     rs2_data,
    output cpu_types_pkg::reg_idx_t  rs1_idx,
    output cpu_types_pkg::reg_idx_t  rs2_idx,
    output logic                     wr_en,
    output cpu_types_pkg::reg_idx_t  wr_idx,
    output cpu_types_pkg::data_t     wr_data,
    output logic                     structural_hazard,
    output logic                     squash,
    output cpu_types_pkg::addr_t     redirect_pc,
    output logic                     halt,
    output logic                     completed,
    output cpu_isa_pkg::exc_code_t   error_status,
    output cpu_types_pkg::addr_t     commit_npc
);

    // multiply sequencer
    typedef enum logic {
        st_idle,
        st_mul_wait
    } mul_state_t;

    mul_state_t state;
    cpu_types_pkg::data_t mul_q;
    cpu_types_pkg::data_t imm_ext;
    logic halted;
    cpu_isa_pkg::exc_code_t err_q;
    cpu_isa_pkg::exc_code_t cur_err;

    logic live;
    logic is_mul;
    logic commit_now;
    logic stop_now;

    assign rs1_idx = pkt.rs1;
    assign rs2_idx = pkt.rs2;

    // nothing runs once halted
    assign live   = pkt.valid && !halted;
    assign is_mul = live && !pkt.illegal && (pkt.op == cpu_isa_pkg::op_mul);

    // first mul cycle holds the front end
    assign structural_hazard = is_mul && (state == st_idle);
    assign commit_now = live && !structural_hazard;

    ////////////////////////////////////////////////////////////////////////////
    // alu
    ////////////////////////////////////////////////////////////////////////////

    assign imm_ext = {{(cpu_types_pkg::xlen-16){pkt.imm[15]}}, pkt.imm};

    always_comb begin
        case (pkt.op)
            cpu_isa_pkg::op_addi: wr_data = rs1_data + imm_ext;
            cpu_isa_pkg::op_add:  wr_data = rs1_data + rs2_data;
            cpu_isa_pkg::op_sub:  wr_data = rs1_data - rs2_data;
            cpu_isa_pkg::op_mul:  wr_data = mul_q;
            default:              wr_data = '0;
        endcase
    end

    assign wr_en  = commit_now && pkt.writes_rd;
    assign wr_idx = pkt.rd;

    ////////////////////////////////////////////////////////////////////////////
    // branch resolve
    ////////////////////////////////////////////////////////////////////////////

    // target is pc plus four times the word offset
    assign redirect_pc = pkt.pc + {pkt.imm[13:0], 2'b00};
    assign squash = commit_now && !pkt.illegal && (pkt.op == cpu_isa_pkg::op_beq) &&
                    (rs1_data == rs2_data);
    assign commit_npc = squash ? redirect_pc : pkt.npc;

    ////////////////////////////////////////////////////////////////////////////
    // commit and exceptions
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (pkt.illegal) begin
            cur_err = cpu_isa_pkg::illegal_inst;
        end else if (pkt.op == cpu_isa_pkg::op_halt) begin
            cur_err = cpu_isa_pkg::halted_on_wfi;
        end else begin
            cur_err = cpu_isa_pkg::no_error;
        end
    end

    assign stop_now     = commit_now && (cur_err != cpu_isa_pkg::no_error);
    assign completed    = commit_now;
    // halt also reaches fetch in the commit cycle
    assign halt         = halted || stop_now;
    assign error_status = halted ? err_q : (commit_now ? cur_err : cpu_isa_pkg::no_error);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state  <= st_idle;
            halted <= 1'b0;
            err_q  <= cpu_isa_pkg::no_error;
        end else begin
            // mul_wait always lasts one cycle
            state <= structural_hazard ? st_mul_wait : st_idle;
            if (stop_now) begin
                halted <= 1'b1;
                err_q  <= cur_err;
            end
        end
    end

    // low word of the product
    always_ff @(posedge clock) begin
        if (structural_hazard) begin
            mul_q <= rs1_data * rs2_data;
        end
    end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                    clock,
    input  logic                    rst_n,
    input  cpu_types_pkg::reg_idx_t rs1_idx,
    input  cpu_types_pkg::reg_idx_t rs2_idx,
    output cpu_types_pkg::data_t    rs1_data,
    output cpu_types_pkg::data_t    rs2_data,
    input  logic                    wr_en,
    input  cpu_types_pkg::reg_idx_t wr_idx,
    input  cpu_types_pkg::data_t    wr_data
);

    cpu_types_pkg::data_t regs [cpu_types_pkg::num_regs];

    // write port that never writes r0
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < cpu_types_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // async reads
    // r0 reads zero
    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

//--- hdl/cpu.sv
`timescale 1ns/1ns

module cpu (
    input  logic                    clock,
    input  logic                    rst_n,
    input  cpu_types_pkg::mem_tag_t mem2proc_transaction_tag,
    input  cpu_types_pkg::data_t    mem2proc_data,
    input  cpu_types_pkg::mem_tag_t mem2proc_data_tag,
    output cpu_types_pkg::mem_cmd_t proc2mem_command,
    output cpu_types_pkg::addr_t    proc2mem_addr,
    output logic                    completed_insts,
    output cpu_isa_pkg::exc_code_t  error_status,
    output cpu_types_pkg::reg_idx_t commit_wr_idx,
    output cpu_types_pkg::data_t    commit_wr_data,
    output logic                    commit_wr_en,
    output cpu_types_pkg::addr_t    commit_npc
);

    ////////////////////////////////////////////////////////////////////////////
    // pipeline wires
    ////////////////////////////////////////////////////////////////////////////

    logic structural_hazard;
    logic squash;
    logic halt;
    logic stall;
    cpu_types_pkg::addr_t redirect_pc;

    // fetch output and if/id register contents
    if_id_if if_fetch ();
    if_id_if if_reg ();

    cpu_isa_pkg::decode_pkt_t id_pkt;
    cpu_isa_pkg::decode_pkt_t ex_pkt;

    cpu_types_pkg::reg_idx_t rs1_idx;
    cpu_types_pkg::reg_idx_t rs2_idx;
    cpu_types_pkg::data_t    rs1_data;
    cpu_types_pkg::data_t    rs2_data;

    // squash wins over the mul stall
    assign stall = squash ? 1'b0 : structural_hazard;

    stage_fetch fetch_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .stall        (stall),
        .squash       (squash),
        .redirect_pc  (redirect_pc),
        .halt         (halt),
        .mem_txn_tag  (mem2proc_transaction_tag),
        .mem_data     (mem2proc_data),
        .mem_data_tag (mem2proc_data_tag),
        .mem_cmd      (proc2mem_command),
        .mem_addr     (proc2mem_addr),
        .fetch        (if_fetch)
    );

    // if/id register loads whenever the front end is not stalled
    always_ff @(posedge clock) begin
        if (!rst_n || squash) begin
            if_reg.valid <= 1'b0;
        end else if (!stall) begin
            if_reg.valid <= if_fetch.valid;
        end
        if (!stall) begin
            if_reg.pc   <= if_fetch.pc;
            if_reg.npc  <= if_fetch.npc;
            if_reg.inst <= if_fetch.inst;
        end
    end

    stage_decode decode_i (
        .inst_in (if_reg),
        .pkt     (id_pkt)
    );

    // decode register with the same enable and clear
    always_ff @(posedge clock) begin
        if (!rst_n || squash) begin
            ex_pkt <= '0;
        end else if (!stall) begin
            ex_pkt <= id_pkt;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // execute, commit and registers
    ////////////////////////////////////////////////////////////////////////////

    exec_commit exec_i (
        .clock             (clock),
        .rst_n             (rst_n),
        .pkt               (ex_pkt),
        .rs1_data          (rs1_data),
        .rs2_data          (rs2_data),
        .rs1_idx           (rs1_idx),
        .rs2_idx           (rs2_idx),
        .wr_en             (commit_wr_en),
        .wr_idx            (commit_wr_idx),
        .wr_data           (commit_wr_data),
        .structural_hazard (structural_hazard),
        .squash            (squash),
        .redirect_pc       (redirect_pc),
        .halt              (halt),
        .completed         (completed_insts),
        .error_status      (error_status),
        .commit_npc        (commit_npc)
    );

    // written from the commit port
    reg_file regs_i (
        .clock    (clock),
        .rst_n    (rst_n),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (commit_wr_en),
        .wr_idx   (commit_wr_idx),
        .wr_data  (commit_wr_data)
    );

endmodule

//--- sim/cpu_sva.sv
`timescale 1ns/1ns

// protocol checks bound into the cpu top level
module cpu_sva (
    input logic                    clock,
    input logic                    rst_n,
    input cpu_types_pkg::mem_cmd_t proc2mem_command,
    input logic                    completed_insts,
    input logic                    commit_wr_en,
    input cpu_types_pkg::reg_idx_t commit_wr_idx,
    input logic                    squash,
    input logic                    structural_hazard
);

    ////////////////////////////////////////////////////////////////////////////
    // fetch side
    ////////////////////////////////////////////////////////////////////////////

    // memory bus quiet through reset
    quiet_in_reset: assert property (@(posedge clock)
        !rst_n |-> proc2mem_command == cpu_types_pkg::mem_none)
        else $error("memory command issued during reset");

    ////////////////////////////////////////////////////////////////////////////
    // commit side
    ////////////////////////////////////////////////////////////////////////////

    // squash is a single cycle pulse
    squash_one_cycle: assert property (@(posedge clock) disable iff (!rst_n)
        squash |=> !squash)
        else $error("squash held longer than one cycle");

    // mul holds its first cycle and commits in the second
    no_commit_in_hazard: assert property (@(posedge clock) disable iff (!rst_n)
        structural_hazard |-> !completed_insts ##1 completed_insts)
        else $error("multiply did not commit right after its hazard cycle");

    // r0 is never a write target
    write_not_r0: assert property (@(posedge clock) disable iff (!rst_n)
        commit_wr_en |-> commit_wr_idx != '0)
        else $error("register write to index zero");

endmodule

//--- sim/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb;

    logic                    clock;
    logic                    rst_n;
    cpu_types_pkg::mem_tag_t mem2proc_transaction_tag;
    cpu_types_pkg::data_t    mem2proc_data;
    cpu_types_pkg::mem_tag_t mem2proc_data_tag;
    cpu_types_pkg::mem_cmd_t proc2mem_command;
    cpu_types_pkg::addr_t    proc2mem_addr;
    logic                    completed_insts;
    cpu_isa_pkg::exc_code_t  error_status;
    cpu_types_pkg::reg_idx_t commit_wr_idx;
    cpu_types_pkg::data_t    commit_wr_data;
    logic                    commit_wr_en;
    cpu_types_pkg::addr_t    commit_npc;

    // program memory shared by the bus model and the reference model
    logic [31:0] prog [64];
    // in-flight responses
    int          rsp_due [$];
    logic [3:0]  rsp_tag [$];
    logic [31:0] rsp_data [$];
    logic [3:0]  next_tag;
    logic [31:0] rng;
    int          cyc;
    int          pick;
    logic        seen_rsp;
    // reference model state
    logic [15:0] m_pc;
    logic [31:0] m_regs [8];
    logic        m_halted;
    logic [1:0]  m_err;
    int          commits;
    int          value_errors;
    int          other_errors;

    cpu cpu_i (.*);

    bind cpu cpu_sva cpu_sva_i (
        .clock             (clock),
        .rst_n             (rst_n),
        .proc2mem_command  (proc2mem_command),
        .completed_insts   (completed_insts),
        .commit_wr_en      (commit_wr_en),
        .commit_wr_idx     (commit_wr_idx),
        .squash            (squash),
        .structural_hazard (structural_hazard)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // op, rd, rs1, rs2, three spare bits, immediate
    function automatic logic [31:0] enc(input logic [3:0] op, input logic [2:0] rd,
                                        input logic [2:0] rs1, input logic [2:0] rs2,
                                        input logic [15:0] imm);
        return {op, rd, rs1, rs2, 3'b000, imm};
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        assert (act === exp) else begin
            value_errors++;
            $display("error %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic report_fail(input string msg);
        other_errors++;
        $display("%0t %s", $time, msg);
    endtask

    // unused words are illegal and carry their own address
    task automatic clear_prog();
        for (int i = 0; i < 64; i++) begin
            prog[i] = {4'hf, 12'h000, 16'(i)};
        end
    endtask

    task automatic do_reset();
        #1 rst_n = 1'b0;
        repeat (8) @(posedge clock);
        m_pc     = 16'h0000;
        m_halted = 1'b0;
        m_err    = 2'd0;
        commits  = 0;
        seen_rsp = 1'b0;
        for (int i = 0; i < 8; i++) begin
            m_regs[i] = '0;
        end
        #1 rst_n = 1'b1;
    endtask

    // bounded wait for the model to stop
    task automatic wait_halt(input int limit);
        int n;
        n = 0;
        while (!m_halted && n < limit) begin
            @(posedge clock);
            n++;
        end
        assert (m_halted) else report_fail("timeout waiting for the core to halt");
        // watch for stray commits after the stop
        repeat (30) @(posedge clock);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tagged memory model
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        mem2proc_transaction_tag = '0;
        mem2proc_data            = '0;
        mem2proc_data_tag        = '0;
        next_tag                 = 4'd1;
        rng                      = 32'h9b43_746e;
        cyc                      = 0;
        forever begin
            @(posedge clock);
            #1;
            mem2proc_transaction_tag = '0;
            mem2proc_data_tag        = '0;
            if (!rst_n) begin
                rsp_due.delete();
                rsp_tag.delete();
                rsp_data.delete();
            end else begin
                cyc++;
                if (proc2mem_command == cpu_types_pkg::mem_load) begin
                    rng = xorshift(rng);
                    // about a quarter of requests see busy
                    if (rng[1:0] != 2'b00) begin
                        mem2proc_transaction_tag = next_tag;
                        rsp_tag.push_back(next_tag);
                        rsp_data.push_back(prog[proc2mem_addr[7:2]]);
                        rsp_due.push_back(cyc + 1 + int'((rng >> 8) % 32'd5));
                        next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                    end
                end
                // one response per cycle with the oldest due first
                pick = -1;
                for (int k = 0; k < rsp_due.size(); k++) begin
                    if (pick < 0 && rsp_due[k] <= cyc) begin
                        pick = k;
                    end
                end
                if (pick >= 0) begin
                    mem2proc_data     = rsp_data[pick];
                    mem2proc_data_tag = rsp_tag[pick];
                    seen_rsp          = 1'b1;
                    rsp_due.delete(pick);
                    rsp_tag.delete(pick);
                    rsp_data.delete(pick);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model and commit checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic model_step();
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic [15:0] imm;
        logic [15:0] npc;
        logic [1:0]  err;
        logic        alu;
        inst = prog[m_pc[7:2]];
        imm  = inst[15:0];
        a    = m_regs[inst[24:22]];
        b    = m_regs[inst[21:19]];
        val  = '0;
        alu  = 1'b1;
        err  = 2'd0;
        npc  = m_pc + 16'd4;
        case (inst[31:28])
            4'h0: val = a + 32'($signed(imm));
            4'h1: val = a + b;
            4'h2: val = a - b;
            4'h3: val = a * b;
            4'h4: begin
                alu = 1'b0;
                // word offset from the branch itself
                if (a == b) begin
                    npc = m_pc + imm * 16'd4;
                end
            end
            4'h5: begin
                alu = 1'b0;
                err = 2'd1;
            end
            default: begin
                alu = 1'b0;
                err = 2'd2;
            end
        endcase
        alu = alu && (inst[27:25] != 3'd0);
        check_val("commit_wr_en", {31'b0, alu}, {31'b0, commit_wr_en});
        if (alu) begin
            check_val("commit_wr_idx", {29'b0, inst[27:25]}, {29'b0, commit_wr_idx});
            check_val("commit_wr_data", val, commit_wr_data);
            m_regs[inst[27:25]] = val;
        end
        check_val("commit_npc", {16'b0, npc}, {16'b0, commit_npc});
        check_val("error_status", {30'b0, err}, {30'b0, error_status});
        m_pc = npc;
        commits++;
        if (err != 2'd0) begin
            m_halted = 1'b1;
            m_err    = err;
        end
    endtask

    always @(negedge clock) begin
        if (rst_n) begin
            if (!seen_rsp) begin
                assert (!completed_insts) else report_fail("commit before any response");
            end
            if (completed_insts) begin
                assert (!m_halted) else report_fail("commit after the core stopped");
                if (!m_halted) model_step();
            end else begin
                assert (!commit_wr_en) else report_fail("register write without commit");
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // programs
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_arith_branch();
        clear_prog();
        prog[0]  = enc(4'h0, 3'd1, 3'd0, 3'd0, 16'd5);
        prog[1]  = enc(4'h0, 3'd2, 3'd1, 3'd0, 16'd7);
        prog[2]  = enc(4'h1, 3'd3, 3'd1, 3'd2, 16'd0);
        prog[3]  = enc(4'h2, 3'd4, 3'd3, 3'd1, 16'd0);
        prog[4]  = enc(4'h3, 3'd5, 3'd3, 3'd4, 16'd0);
        // minus one added to the product
        prog[5]  = enc(4'h0, 3'd6, 3'd5, 3'd0, 16'hffff);
        prog[6]  = enc(4'h3, 3'd7, 3'd6, 3'd6, 16'd0);
        // taken branch skips two marker words
        prog[7]  = enc(4'h4, 3'd0, 3'd4, 3'd2, 16'd3);
        prog[8]  = enc(4'h0, 3'd1, 3'd0, 3'd0, 16'd100);
        prog[9]  = enc(4'h0, 3'd2, 3'd0, 3'd0, 16'd200);
        // not taken
        prog[10] = enc(4'h4, 3'd0, 3'd1, 3'd2, 16'd5);
        prog[11] = enc(4'h2, 3'd1, 3'd0, 3'd3, 16'd0);
        prog[12] = enc(4'h3, 3'd2, 3'd1, 3'd4, 16'd0);
        prog[13] = enc(4'h1, 3'd0, 3'd1, 3'd1, 16'd0);
        prog[14] = enc(4'h0, 3'd3, 3'd0, 3'd0, 16'd1);
        prog[15] = enc(4'h4, 3'd0, 3'd0, 3'd0, 16'd2);
        prog[16] = enc(4'h0, 3'd3, 3'd0, 3'd0, 16'd99);
        // counted loop of six passes
        prog[17] = enc(4'h0, 3'd7, 3'd0, 3'd0, 16'd6);
        prog[18] = enc(4'h0, 3'd6, 3'd0, 3'd0, 16'd0);
        prog[19] = enc(4'h0, 3'd6, 3'd6, 3'd0, 16'd1);
        prog[20] = enc(4'h4, 3'd0, 3'd6, 3'd7, 16'd2);
        // backward by two words
        prog[21] = enc(4'h4, 3'd0, 3'd0, 3'd0, 16'hfffe);
        prog[22] = enc(4'h1, 3'd1, 3'd6, 3'd7, 16'd0);
        prog[23] = enc(4'h5, 3'd0, 3'd0, 3'd0, 16'd0);
    endtask

    task automatic load_illegal();
        clear_prog();
        prog[0] = enc(4'h0, 3'd1, 3'd0, 3'd0, 16'd3);
        prog[1] = enc(4'h1, 3'd2, 3'd1, 3'd1, 16'd0);
        prog[2] = 32'hf000_0000;
        prog[3] = enc(4'h0, 3'd3, 3'd0, 3'd0, 16'd1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rst_n        = 1'b0;
        value_errors = 0;
        other_errors = 0;
        seen_rsp     = 1'b0;
        m_halted     = 1'b0;

        load_arith_branch();
        do_reset();
        wait_halt(4000);
        check_val("commit count", 32'd35, commits);
        check_val("halt code", 32'd1, {30'b0, m_err});

        load_illegal();
        do_reset();
        wait_halt(2000);
        check_val("commit count", 32'd3, commits);
        check_val("halt code", 32'd2, {30'b0, m_err});

        $display("value errors %0d, other errors %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- cpu.f
hdl/cpu_types_pkg.sv
hdl/cpu_isa_pkg.sv
hdl/if_id_if.sv
hdl/stage_fetch.sv
hdl/stage_decode.sv
hdl/exec_commit.sv
hdl/reg_file.sv
hdl/cpu.sv
sim/cpu_sva.sv
sim/cpu_tb.sv

//--- Makefile
# Verilator build for the cpu core and its testbench

VERILATOR = verilator
FLAGS     = --timing -Wno-fatal
TOP       = cpu_tb
FILELIST  = cpu.f
OBJ_DIR   = obj_dir
PASS_MSG  = Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
